// File: Makefile
# Verilator flow for the memory back end

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_mem_back_end
RTL_TOP   ?= mem_back_end
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# the binary exits with a failing status when the testbench stops on $fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TB_TOP) \
		-f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TB_TOP)
	$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int ADDR_W      = mem_pipe_pkg::ADDR_W_DEFAULT,
    parameter int WAIT_STATES = 1
) (
    input logic clk,
    input logic rst_n,
    wb_if.slave bus
);
    import mem_pipe_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    u32_t             mem [DEPTH];
    logic [CNT_W-1:0] wait_cnt;
    logic             ack_r;
    logic             req;
    logic             ack_set;

    assign req     = bus.cyc & bus.stb;
    assign ack_set = req & ~ack_r & (wait_cnt == CNT_W'(WAIT_STATES));
    assign bus.ack = ack_r & req;  // never seen once the master has let go

    initial begin
        for (int i = 0; i < DEPTH; i++) mem[i] = '0;
    end

    // the count restarts after every ack and whenever stb drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            ack_r    <= 1'b0;
        end else if (!req || ack_r) begin
            wait_cnt <= '0;
            ack_r    <= 1'b0;
        end else if (ack_set) begin
            ack_r <= 1'b1;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_set) bus.dat_r <= mem[bus.adr];
    end

    always @(posedge clk) begin
        if (bus.ack && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.sel[i]) mem[bus.adr][8*i +: 8] <= bus.dat_w[8*i +: 8];  // enabled lanes only
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem1_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem1_stage #(
    parameter int ADDR_W = mem_pipe_pkg::ADDR_W_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   in_valid,
    input  mem_pipe_pkg::exec_op_t in_op,
    output logic                   in_rdy,
    stage_if.producer              out
);
    import mem_pipe_pkg::*;

    exec_op_t        op_r;
    logic            valid_r;
    u32_t            byte_addr;
    mem1_mem2_pass_t pass;

    assign in_rdy = ~valid_r | flush | (out.valid & out.rdy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (flush) begin
            valid_r <= 1'b0;
        end else if (in_rdy) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_rdy && in_valid) op_r <= in_op;
    end

    // ************************************************************
    // address, byte lanes and store placement

    assign byte_addr = op_r.base + op_r.offset;

    always_comb begin
        pass           = '0;
        pass.valid     = valid_r;
        pass.is_mem    = op_r.is_mem;
        pass.is_store  = op_r.is_store;
        pass.is_signed = op_r.is_signed;
        pass.byte_type = op_r.byte_type;
        pass.byte_off  = byte_addr[1:0];
        pass.addr      = 30'(byte_addr[ADDR_W+1:2]);  // wraps inside the RAM
        pass.is_wr_rd  = op_r.is_wr_rd;
        pass.rd        = op_r.rd;
        pass.ex_out    = op_r.ex_out;
        case (op_r.byte_type)
            BYTE: begin
                pass.sel      = 4'b0001 << byte_addr[1:0];
                pass.st_lanes = {4{op_r.st_data[7:0]}};
            end
            HALF_WORD: begin
                pass.sel      = byte_addr[1] ? 4'b1100 : 4'b0011;
                pass.st_lanes = {2{op_r.st_data[15:0]}};
            end
            default: begin
                pass.sel      = 4'b1111;
                pass.st_lanes = op_r.st_data;
            end
        endcase
    end

    assign out.valid   = pass.valid;
    assign out.payload = pass;

endmodule

`default_nettype wire

// File: design/mem2_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem2_stage #(
    parameter int ADDR_W = mem_pipe_pkg::ADDR_W_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    stage_if.consumer                  in,
    stage_if.producer                  out,
    wb_if.master                       bus,
    output mem_pipe_pkg::forward_req_t fwd
);
    import mem_pipe_pkg::*;

    mem1_mem2_pass_t pass_r;
    logic            valid_r;
    logic            bus_stall;
    logic            mem2_empty;
    logic [7:0]      mem_byte;
    logic [15:0]     mem_half;
    u32_t            mem_out;
    mem2_wb_pass_t   pass_out;

    // a held memory op waits for ack, loads and stores alike
    assign bus_stall  = valid_r & pass_r.is_mem & ~bus.ack;
    assign mem2_empty = flush | ~valid_r;
    assign in.rdy     = mem2_empty | (~bus_stall & out.rdy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (flush) begin
            valid_r <= 1'b0;
        end else if (in.rdy) begin
            valid_r <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.rdy && in.valid) pass_r <= in.payload;
    end

    // ************************************************************
    // data bus

    assign bus.cyc   = valid_r & pass_r.is_mem;
    assign bus.stb   = valid_r & pass_r.is_mem;
    assign bus.we    = pass_r.is_store;
    assign bus.adr   = pass_r.addr[ADDR_W-1:0];
    assign bus.sel   = pass_r.sel;
    assign bus.dat_w = pass_r.st_lanes;

    // an unfinished load forwards its address, so the consumer must stall on load-use
    assign fwd.valid = valid_r & pass_r.is_wr_rd & ~flush;
    assign fwd.idx   = pass_r.rd;
    assign fwd.data  = pass_r.ex_out;

    // ************************************************************
    // load alignment and extension

    always_comb begin
        case (pass_r.byte_off)
            2'b00:   mem_byte = bus.dat_r[7:0];
            2'b01:   mem_byte = bus.dat_r[15:8];
            2'b10:   mem_byte = bus.dat_r[23:16];
            default: mem_byte = bus.dat_r[31:24];
        endcase
    end

    assign mem_half = pass_r.byte_off[1] ? bus.dat_r[31:16] : bus.dat_r[15:0];

    always_comb begin
        case (pass_r.byte_type)
            BYTE:      mem_out = {{24{pass_r.is_signed & mem_byte[7]}}, mem_byte};
            HALF_WORD: mem_out = {{16{pass_r.is_signed & mem_half[15]}}, mem_half};
            default:   mem_out = bus.dat_r;
        endcase
    end

    always_comb begin
        pass_out          = '0;
        pass_out.valid    = valid_r & ~flush & ~bus_stall;
        pass_out.is_wr_rd = pass_r.is_wr_rd;
        pass_out.is_store = pass_r.is_store;
        pass_out.rd       = pass_r.rd;
        pass_out.result   = pass_r.is_mem ? mem_out : pass_r.ex_out;
    end

    assign out.valid   = pass_out.valid;
    assign out.payload = pass_out;

endmodule

`default_nettype wire

// File: design/mem_back_end.sv
`timescale 1ns/1ps
`default_nettype none

module mem_back_end #(
    parameter int ADDR_W      = mem_pipe_pkg::ADDR_W_DEFAULT,
    parameter int WAIT_STATES = 1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       in_valid,
    input  mem_pipe_pkg::exec_op_t     in_op,
    output logic                       in_rdy,
    output logic                       commit_valid,
    output logic                       commit_we,
    output mem_pipe_pkg::reg_idx_t     commit_rd,
    output mem_pipe_pkg::u32_t         commit_data,
    output mem_pipe_pkg::forward_req_t fwd_mem2,
    output mem_pipe_pkg::forward_req_t fwd_wb
);
    import mem_pipe_pkg::*;

    stage_if #(.payload_t(mem1_mem2_pass_t)) m1_m2 ();
    stage_if #(.payload_t(mem2_wb_pass_t))   m2_wb ();
    wb_if #(.ADDR_W(ADDR_W))                 dbus ();

    mem1_stage #(.ADDR_W(ADDR_W)) mem1_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_rdy   (in_rdy),
        .out      (m1_m2)
    );

    mem2_stage #(.ADDR_W(ADDR_W)) mem2_i (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .in    (m1_m2),
        .out   (m2_wb),
        .bus   (dbus),
        .fwd   (fwd_mem2)
    );

    data_ram #(
        .ADDR_W      (ADDR_W),
        .WAIT_STATES (WAIT_STATES)
    ) data_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (dbus)
    );

    writeback_stage writeback_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (m2_wb),
        .commit_valid (commit_valid),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .fwd          (fwd_wb)
    );

endmodule

`default_nettype wire

// File: design/mem_pipe_pkg.sv
`default_nettype none

package mem_pipe_pkg;

    localparam int ADDR_W_DEFAULT = 10;

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } byte_type_e;

    // op as handed over by execute
    typedef struct packed {
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_e byte_type;
        logic       is_wr_rd;
        reg_idx_t   rd;
        u32_t       ex_out;
        u32_t       base;
        u32_t       offset;
        u32_t       st_data;
    } exec_op_t;

    typedef struct packed {
        logic        valid;
        logic        is_mem;
        logic        is_store;
        logic        is_signed;
        byte_type_e  byte_type;
        logic [1:0]  byte_off;
        logic [29:0] addr;      // word address
        logic [3:0]  sel;
        u32_t        st_lanes;
        logic        is_wr_rd;
        reg_idx_t    rd;
        u32_t        ex_out;
    } mem1_mem2_pass_t;

    typedef struct packed {
        logic     valid;
        logic     is_wr_rd;
        logic     is_store;
        reg_idx_t rd;
        u32_t     result;
    } mem2_wb_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        u32_t     data;
    } forward_req_t;

endpackage

`default_nettype wire

// File: design/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// the same handoff carries different stage payloads
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     rdy;
    payload_t payload;

    modport producer (output valid, payload, input rdy);
    modport consumer (input valid, payload, output rdy);

endinterface

`default_nettype wire

// File: design/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if #(
    parameter int ADDR_W = mem_pipe_pkg::ADDR_W_DEFAULT
) ();
    import mem_pipe_pkg::*;

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;  // word address
    logic [3:0]        sel;
    u32_t              dat_w;
    u32_t              dat_r;
    logic              ack;

    modport master (output cyc, stb, we, adr, sel, dat_w, input dat_r, ack);
    modport slave (input cyc, stb, we, adr, sel, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

// File: design/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    stage_if.consumer                  in,
    output logic                       commit_valid,
    output logic                       commit_we,
    output mem_pipe_pkg::reg_idx_t     commit_rd,
    output mem_pipe_pkg::u32_t         commit_data,
    output mem_pipe_pkg::forward_req_t fwd
);
    import mem_pipe_pkg::*;

    mem2_wb_pass_t pass_r;
    logic          valid_r;

    // nothing downstream can stall retirement
    assign in.rdy = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) pass_r <= in.payload;
    end

    assign commit_valid = valid_r;
    assign commit_we    = pass_r.is_wr_rd;
    assign commit_rd    = pass_r.rd;
    assign commit_data  = pass_r.result;

    // second forwarding source, the value being written this cycle
    assign fwd.valid = commit_valid & commit_we;
    assign fwd.idx   = commit_rd;
    assign fwd.data  = commit_data;

endmodule

`default_nettype wire

// File: sources.f
+incdir+verification
design/mem_pipe_pkg.sv
design/wb_if.sv
design/stage_if.sv
design/mem1_stage.sv
design/mem2_stage.sv
design/data_ram.sv
design/writeback_stage.sv
design/mem_back_end.sv
verification/tb_mem_back_end.sv

// File: verification/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ************************************************************
// reference memory, op generator and expected commits

localparam u32_t WIN_BASE   = 32'h0000_0040;  // 16 words so that loads hit earlier stores
localparam u32_t LFSR_TAPS  = 32'h8020_0003;
localparam int   K_ANY      = -1;
localparam int   K_ALU      = 0;
localparam int   K_LOAD     = 1;
localparam int   K_STORE    = 2;
localparam int   K_NO_STORE = 3;

typedef struct packed {
    logic     is_load;
    logic     we;
    reg_idx_t rd;
    u32_t     data;
    u32_t     ex_out;
} commit_exp_t;

u32_t        ref_mem [16] = '{default: 32'h0};
commit_exp_t exp_q [$];
int          issued = 0;
int          committed = 0;
int          dropped = 0;
logic [31:0] lfsr_state = 32'd39;

// one Galois step per bit, first bit lands in the msb of the result
function automatic u32_t take_bits(input int n);
    u32_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
    end
    return v;
endfunction

function automatic exec_op_t gen_op(input int kind, input int btype, input int word);
    exec_op_t   op;
    int         k;
    u32_t       addr;
    logic [1:0] r;
    op = '0;
    k = kind;
    r = 2'(take_bits(2));
    if (kind == K_ANY || kind == K_NO_STORE) begin
        k = (r == 2'd2) ? K_LOAD : (r == 2'd3 && kind == K_ANY) ? K_STORE : K_ALU;
    end
    r = 2'(take_bits(2));
    op.is_mem    = (k != K_ALU);
    op.is_store  = (k == K_STORE);
    op.is_wr_rd  = (k == K_LOAD) || (k == K_ALU && r != 2'd0);
    op.is_signed = (take_bits(1) != 0);
    op.rd        = 5'(take_bits(5));
    op.st_data   = take_bits(32);
    r = 2'(take_bits(2));
    if (btype >= 0) r = 2'(btype);
    op.byte_type = (r == 2'd3) ? WORD : byte_type_e'(r);
    addr = WIN_BASE + (take_bits(4) << 2);
    addr = addr + take_bits(2);
    if (word >= 0) addr[5:2] = 4'(word);
    if (op.byte_type == HALF_WORD) addr[0] = 1'b0;
    if (op.byte_type == WORD) addr[1:0] = 2'b00;
    op.offset = take_bits(4);
    op.base   = addr - op.offset;
    op.ex_out = op.is_mem ? addr : take_bits(32);  // memory ops carry their address
    return op;
endfunction

// builds the expected commit, stores land in the model right away
function automatic void record_issue(input exec_op_t op);
    commit_exp_t want;
    u32_t        addr;
    u32_t        word;
    logic [7:0]  b;
    logic [15:0] h;
    addr = op.base + op.offset;
    word = ref_mem[addr[5:2]];
    b = 8'(word >> (8 * addr[1:0]));
    h = 16'(word >> (16 * addr[1]));
    want.is_load = op.is_mem & ~op.is_store;
    want.we      = op.is_wr_rd;
    want.rd      = op.rd;
    want.ex_out  = op.ex_out;
    want.data    = op.ex_out;
    if (want.is_load) begin
        case (op.byte_type)
            BYTE:      want.data = {{24{op.is_signed & b[7]}}, b};
            HALF_WORD: want.data = {{16{op.is_signed & h[15]}}, h};
            default:   want.data = word;
        endcase
    end else if (op.is_store) begin
        case (op.byte_type)
            BYTE:      ref_mem[addr[5:2]][8 * addr[1:0] +: 8] = op.st_data[7:0];
            HALF_WORD: ref_mem[addr[5:2]][16 * addr[1] +: 16] = op.st_data[15:0];
            default:   ref_mem[addr[5:2]] = op.st_data;
        endcase
    end
    exp_q.push_back(want);
    issued++;
endfunction

`endif

// File: verification/tb_mem_back_end.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_back_end;
    import mem_pipe_pkg::*;

    localparam int ADDR_W         = 10;
    localparam int WAIT_STATES    = 2;
    localparam int CLK_PERIOD     = 10;
    localparam int IN_DELAY       = 1;
    localparam int RESET_CYCLES   = 4;
    localparam int N_ALU          = 20;
    localparam int N_WORD         = 8;
    localparam int N_SUB          = 40;
    localparam int N_MIX          = 60;
    localparam int N_FLUSH_ROUNDS = 3;
    localparam int N_FLUSH_PRE    = 4;
    localparam int N_FLUSH_POST   = 10;
    localparam int TOTAL_OPS      = N_ALU + 2 * N_WORD + N_SUB + N_MIX
                                  + N_FLUSH_ROUNDS * (N_FLUSH_PRE + N_FLUSH_POST);

    logic         clk = 1'b0;
    logic         rst_n;
    logic         flush;
    logic         in_valid;
    exec_op_t     in_op;
    logic         in_rdy;
    logic         commit_valid;
    logic         commit_we;
    reg_idx_t     commit_rd;
    u32_t         commit_data;
    forward_req_t fwd_mem2;
    forward_req_t fwd_wb;
    string        test_name = "reset";
    logic         fwd_mem2_last = 1'b0;

    `include "tb_model.svh"

    mem_back_end #(
        .ADDR_W      (ADDR_W),
        .WAIT_STATES (WAIT_STATES)
    ) mem_back_end_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_rdy       (in_rdy),
        .commit_valid (commit_valid),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .fwd_mem2     (fwd_mem2),
        .fwd_wb       (fwd_wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_value(input string what, input u32_t expected, input u32_t actual);
        $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic fail_plain(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // ************************************************************
    // commit and forwarding monitor, sampled mid cycle

    task automatic check_forwarding();
        int          pos;
        commit_exp_t m;
        if (!commit_valid) begin
            assert (!fwd_wb.valid) else fail_plain("fwd_wb is valid while nothing commits");
        end
        if (fwd_mem2.valid) begin
            pos = commit_valid ? 1 : 0;  // the op behind the one retiring now
            assert (exp_q.size() > pos) else fail_plain("mem2 forwards while it holds no op");
            m = exp_q[pos];
            assert (m.we) else fail_plain("mem2 forwards for an op that does not write rd");
            if (!m.is_load) begin
                assert (fwd_mem2.idx == m.rd)
                    else fail_value("fwd_mem2.idx", 32'(m.rd), 32'(fwd_mem2.idx));
                assert (fwd_mem2.data == m.ex_out)
                    else fail_value("fwd_mem2.data", m.ex_out, fwd_mem2.data);
            end
        end
    endtask

    task automatic check_commit();
        commit_exp_t want;
        assert (exp_q.size() > 0) else fail_plain("commit seen with no op outstanding");
        want = exp_q.pop_front();
        committed++;
        assert (commit_we == want.we)
            else fail_value("commit_we", 32'(want.we), 32'(commit_we));
        // the retiring op sat in mem2 one cycle ago
        assert (fwd_mem2_last == want.we)
            else fail_value("fwd_mem2.valid", 32'(want.we), 32'(fwd_mem2_last));
        assert (fwd_wb.valid == want.we)
            else fail_value("fwd_wb.valid", 32'(want.we), 32'(fwd_wb.valid));
        if (want.we) begin
            assert (commit_rd == want.rd)
                else fail_value("commit_rd", 32'(want.rd), 32'(commit_rd));
            assert (commit_data == want.data)
                else fail_value("commit_data", want.data, commit_data);
            assert (fwd_wb.idx == want.rd)
                else fail_value("fwd_wb.idx", 32'(want.rd), 32'(fwd_wb.idx));
            assert (fwd_wb.data == want.data)
                else fail_value("fwd_wb.data", want.data, fwd_wb.data);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_forwarding();
            if (commit_valid) check_commit();
        end
        fwd_mem2_last = fwd_mem2.valid;
    end

    // ************************************************************
    // stimulus, every task returns just after a rising edge

    task automatic issue_op(input exec_op_t op);
        logic rdy;
        in_op    = op;
        in_valid = 1'b1;
        rdy      = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            rdy = in_rdy;
            @(posedge clk);
            #IN_DELAY;
        end
        record_issue(op);
    endtask

    task automatic run_burst(input int count, input int kind, input int btype);
        for (int i = 0; i < count; i++) begin
            issue_op(gen_op(kind, btype, -1));  // in_valid stays high through the burst
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #IN_DELAY;
        end
    endtask

    // kills mem1 and mem2, whatever has not committed by then is gone
    task automatic flush_pipe();
        int n;
        in_valid = 1'b0;
        flush    = 1'b1;
        @(posedge clk);
        #IN_DELAY;
        flush = 1'b0;
        n = issued - committed - dropped;
        repeat (n) void'(exp_q.pop_back());
        dropped += n;
    endtask

    initial begin
        int kind;
        int btype;
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_op    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #IN_DELAY rst_n = 1'b1;
        @(negedge clk);
        assert (in_rdy && !commit_valid && !fwd_mem2.valid && !fwd_wb.valid)
            else fail_plain("outputs not idle after reset");
        @(posedge clk);
        #IN_DELAY;

        test_name = "alu_in_order";
        run_burst(N_ALU, K_ALU, -1);
        drain();

        test_name = "word_store_load";
        for (int i = 0; i < N_WORD; i++) begin
            issue_op(gen_op(K_STORE, 2, i));
        end
        for (int i = 0; i < N_WORD; i++) begin
            issue_op(gen_op(K_LOAD, 2, i));
        end
        in_valid = 1'b0;
        drain();

        test_name = "subword_merge_extend";
        for (int i = 0; i < N_SUB; i++) begin
            kind  = (take_bits(1) != 0) ? K_STORE : K_LOAD;
            btype = int'(take_bits(1));
            issue_op(gen_op(kind, btype, -1));
        end
        in_valid = 1'b0;
        drain();

        test_name = "backpressure_mix";
        run_burst(N_MIX, K_ANY, -1);
        drain();

        test_name = "flush";
        for (int r = 0; r < N_FLUSH_ROUNDS; r++) begin
            run_burst(N_FLUSH_PRE, K_NO_STORE, -1);  // no store in flight at the flush
            flush_pipe();
            run_burst(N_FLUSH_POST, K_ANY, -1);
            drain();
        end

        // stray commits after the last drain still reach the monitor
        repeat (2 * (WAIT_STATES + 4)) @(posedge clk);
        @(negedge clk);

        if (in_rdy && exp_q.size() == 0 && committed + dropped == issued) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("ERROR: pipeline not idle, %0d issued, %0d committed, %0d flushed",
                     issued, committed, dropped);
            $display("SOME TESTS FAILED");
            $fatal(1, "pipeline not idle at the end of the run");
        end
    end

    // generous bound of 40 cycles per op
    initial begin
        #(CLK_PERIOD * (40 * TOTAL_OPS + 100));
        $display("ERROR: watchdog expired in %s before the tests finished", test_name);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
